// File: vlog.f
source/lsu_pkg.sv
source/lsu_issue.sv
source/lsu_store_lanes.sv
source/lsu_write_fsm.sv
source/lsu_read_fsm.sv
source/lsu_load_align.sv
source/lsu_top.sv
tests/lsu_checker.sv
tests/lsu_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f vlog.f --top-module lsu_tb -o lsu_sim
	./obj_dir/lsu_sim | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tests/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;

	localparam int NUM_REQ        = 400;
	localparam int CYCLES_PER_REQ = 40;
	localparam int CYCLE_LIMIT    = NUM_REQ * CYCLES_PER_REQ;
	localparam int MEM_BYTES      = 512;

	logic               clock;
	logic               reset;
	logic               req_valid;
	logic               req_is_store;
	lsu_pkg::mem_op_u   req_op;
	logic [31:0]        req_addr;
	lsu_pkg::word_t     req_wdata;
	lsu_pkg::reg_addr_t req_rd;
	logic               req_ready;
	logic               aw_valid;
	logic [31:0]        aw_addr;
	logic               aw_ready;
	logic               w_valid;
	lsu_pkg::bus_t      w_data;
	lsu_pkg::strb_t     w_strb;
	logic               w_ready;
	logic               b_valid;
	logic               b_ready;
	logic               ar_valid;
	logic [31:0]        ar_addr;
	logic               ar_ready;
	logic               r_valid;
	lsu_pkg::bus_t      r_data;
	logic               r_ready;
	logic               rf_wen;
	lsu_pkg::reg_addr_t rf_waddr;
	lsu_pkg::word_t     rf_wdata;
	logic               done;

	// slave memory and the reference copy it must end up equal to
	logic [7:0]         slave_mem [MEM_BYTES];
	logic [7:0]         model_mem [MEM_BYTES];
	logic [31:0]        exp_ar_q [$];
	logic [31:0]        exp_aw_q [$];

	// the one request sitting in the stage
	logic               in_flight;
	logic               cur_is_store;
	logic [8:0]         cur_addr;
	int                 cur_bytes;
	lsu_pkg::word_t     cur_wdata;
	lsu_pkg::word_t     cur_expect;
	lsu_pkg::reg_addr_t cur_rd;
	int                 done_count;

	lsu_top #(
		.ADDR_WIDTH(32)
	) DUT (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	task automatic report_failure();
		$display("TEST FAIL");
		$fatal(1, "stopping at the first error");
	endtask

	// wait 0 to 3 extra cycles and return 1 ns after a rising edge
	task automatic random_wait();
		int n;
		n = $urandom_range(0, 3);
		repeat (n) @(negedge clock);
		@(posedge clock);
		#1;
	endtask

	function automatic int size_bytes(input logic [1:0] size);
		if (size == 2'd0) begin
			return 1;
		end else if (size == 2'd1) begin
			return 2;
		end
		return 4;
	endfunction

	// little endian value from the model, then sign or zero fill
	function automatic lsu_pkg::word_t expected_load(input logic [8:0] addr, input int nbytes,
			input logic is_unsigned);
		lsu_pkg::word_t value;
		logic           sign;
		value = '0;
		for (int i = 0; i < nbytes; i++) begin
			value[8*i +: 8] = model_mem[addr + 9'(i)];
		end
		sign = value[8*nbytes-1] && !is_unsigned;
		for (int i = 8*nbytes; i < 32; i++) begin
			value[i] = sign;
		end
		return value;
	endfunction

	function automatic lsu_pkg::bus_t read_beat(input logic [8:0] base);
		lsu_pkg::bus_t beat;
		for (int i = 0; i < 8; i++) begin
			beat[8*i +: 8] = slave_mem[base + 9'(i)];
		end
		return beat;
	endfunction

	// strobe and lanes of one write beat against the store in the stage
	task automatic check_write_beat(input logic [8:0] base);
		lsu_pkg::strb_t exp_strb;
		logic [8:0]     byte_addr;
		exp_strb = '0;
		for (int i = 0; i < cur_bytes; i++) begin
			byte_addr = cur_addr + 9'(i);
			if (byte_addr[8:3] == base[8:3]) begin
				exp_strb[byte_addr[2:0]] = 1'b1;
				assert (w_data[{byte_addr[2:0], 3'b000} +: 8] == cur_wdata[8*i +: 8]) else begin
					$display("Fail w_data got %h for store data %h", w_data, cur_wdata);
					report_failure();
				end
			end
		end
		assert (w_strb == exp_strb) else begin
			$display("Fail w_strb got %h expected %h", w_strb, exp_strb);
			report_failure();
		end
		for (int j = 0; j < 8; j++) begin
			if (w_strb[j]) begin
				slave_mem[base + 9'(j)] = w_data[8*j +: 8];
			end
		end
	endtask

	task automatic capture_request();
		logic [31:0] low_addr;
		cur_is_store = req_is_store;
		cur_addr     = req_addr[8:0];
		cur_bytes    = size_bytes(req_op.load.size);
		cur_wdata    = req_wdata;
		cur_rd       = req_rd;
		in_flight    = 1'b1;
		low_addr = {req_addr[31:3], 3'b000};
		if (cur_is_store) begin
			exp_aw_q.push_back(low_addr);
			if (int'(req_addr[2:0]) + cur_bytes > 8) begin
				exp_aw_q.push_back(low_addr + 32'd8);
			end
			for (int i = 0; i < cur_bytes; i++) begin
				model_mem[cur_addr + 9'(i)] = cur_wdata[8*i +: 8];
			end
		end else begin
			exp_ar_q.push_back(low_addr);
			if (int'(req_addr[2:0]) + cur_bytes > 8) begin
				exp_ar_q.push_back(low_addr + 32'd8);
			end
			cur_expect = expected_load(cur_addr, cur_bytes, req_op.load.is_unsigned);
		end
	endtask

	task automatic check_done();
		if (done) begin
			assert (in_flight) else begin
				$display("done pulsed with no request in the stage");
				report_failure();
			end
			if (cur_is_store) begin
				assert (!rf_wen && exp_aw_q.size() == 0) else begin
					$display("store finished with rf_wen high or write beats missing");
					report_failure();
				end
			end else begin
				assert (rf_wen && exp_ar_q.size() == 0) else begin
					$display("load finished with rf_wen low or read beats missing");
					report_failure();
				end
				assert (rf_waddr == cur_rd) else begin
					$display("Fail rf_waddr got %h expected %h", rf_waddr, cur_rd);
					report_failure();
				end
				assert (rf_wdata == cur_expect) else begin
					$display("Fail rf_wdata got %h expected %h", rf_wdata, cur_expect);
					report_failure();
				end
			end
			done_count++;
			in_flight = 1'b0;
		end else begin
			assert (!rf_wen && !(in_flight && req_ready)) else begin
				$display("rf_wen outside a done cycle or req_ready high while busy");
				report_failure();
			end
		end
	endtask

	initial begin : monitor
		in_flight  = 1'b0;
		done_count = 0;
		forever begin
			@(negedge clock);
			if (!reset) begin
				check_done();
				if (req_valid && req_ready) begin
					capture_request();
				end
			end
		end
	end

	initial begin : read_slave
		logic [8:0] base;
		ar_ready = 1'b0;
		r_valid  = 1'b0;
		r_data   = '0;
		forever begin
			@(negedge clock);
			if (ar_valid) begin
				random_wait();
				ar_ready = 1'b1;
				@(negedge clock);
				assert (exp_ar_q.size() != 0) else begin
					$display("read beat issued that the request does not need");
					report_failure();
				end
				assert (ar_addr == exp_ar_q[0]) else begin
					$display("Fail ar_addr got %h expected %h", ar_addr, exp_ar_q[0]);
					report_failure();
				end
				void'(exp_ar_q.pop_front());
				base = ar_addr[8:0];
				@(posedge clock);
				#1;
				ar_ready = 1'b0;
				random_wait();
				r_valid = 1'b1;
				r_data  = read_beat(base);
				do @(negedge clock); while (!r_ready);
				@(posedge clock);
				#1;
				r_valid = 1'b0;
			end
		end
	end

	initial begin : write_slave
		logic [8:0] base;
		aw_ready = 1'b0;
		w_ready  = 1'b0;
		b_valid  = 1'b0;
		forever begin
			@(negedge clock);
			if (aw_valid) begin
				random_wait();
				aw_ready = 1'b1;
				@(negedge clock);
				assert (exp_aw_q.size() != 0) else begin
					$display("write beat issued that the request does not need");
					report_failure();
				end
				assert (aw_addr == exp_aw_q[0]) else begin
					$display("Fail aw_addr got %h expected %h", aw_addr, exp_aw_q[0]);
					report_failure();
				end
				void'(exp_aw_q.pop_front());
				base = aw_addr[8:0];
				@(posedge clock);
				#1;
				aw_ready = 1'b0;
				do @(negedge clock); while (!w_valid);
				random_wait();
				w_ready = 1'b1;
				@(negedge clock);
				check_write_beat(base);
				@(posedge clock);
				#1;
				w_ready = 1'b0;
				random_wait();
				b_valid = 1'b1;
				do @(negedge clock); while (!b_ready);
				@(posedge clock);
				#1;
				b_valid = 1'b0;
			end
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		forever begin
			@(posedge clock);
			cycles++;
			if (cycles > CYCLE_LIMIT) begin
				$display("run did not finish within %0d cycles", CYCLE_LIMIT);
				report_failure();
			end
		end
	end

	initial begin : stimulus
		int gap;
		void'($urandom(32'h2c85));
		reset        = 1'b1;
		req_valid    = 1'b0;
		req_is_store = 1'b0;
		req_op       = '0;
		req_addr     = '0;
		req_wdata    = '0;
		req_rd       = '0;
		for (int i = 0; i < MEM_BYTES; i++) begin
			slave_mem[i] = 8'($urandom);
			model_mem[i] = slave_mem[i];
		end
		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;
		@(negedge clock);
		assert (!aw_valid && !w_valid && !b_ready && !ar_valid && !r_ready && !rf_wen && !done
				&& req_ready) else begin
			$display("bus valids, readies, rf_wen, done or req_ready wrong after reset");
			report_failure();
		end
		@(posedge clock);
		#1;
		for (int n = 0; n < NUM_REQ; n++) begin
			// any size at any lane of a 256-byte window
			req_is_store = 1'($urandom_range(0, 1));
			req_op       = {2'($urandom_range(0, 2)), 1'($urandom_range(0, 1))};
			req_addr     = 32'($urandom_range(0, 255));
			req_wdata    = $urandom;
			req_rd       = 5'($urandom_range(0, 31));
			req_valid    = 1'b1;
			do @(negedge clock); while (!req_ready);
			@(posedge clock);
			#1;
			req_valid = 1'b0;
			gap = $urandom_range(0, 3);
			repeat (gap) begin
				@(posedge clock);
				#1;
			end
		end
		wait (done_count == NUM_REQ);
		@(negedge clock);
		for (int i = 0; i < MEM_BYTES; i++) begin
			assert (slave_mem[i] == model_mem[i]) else begin
				$display("Fail slave_mem[%h] got %h expected %h", i, slave_mem[i], model_mem[i]);
				report_failure();
			end
		end
		$display("TEST PASS");
		$finish;
	end

endmodule

// File: tests/lsu_checker.sv
`timescale 1ns/1ps

module lsu_checker #(
	parameter int ADDR_WIDTH = 32
) (
	input logic                  clock,
	input logic                  reset,
	input logic                  aw_valid,
	input logic                  aw_ready,
	input logic [ADDR_WIDTH-1:0] aw_addr,
	input logic                  w_valid,
	input logic                  w_ready,
	input lsu_pkg::bus_t         w_data,
	input lsu_pkg::strb_t        w_strb,
	input logic                  ar_valid,
	input logic                  ar_ready,
	input logic [ADDR_WIDTH-1:0] ar_addr,
	input logic                  done
);

	// a waiting valid keeps its payload
	aw_hold: assert property (@(posedge clock) disable iff (reset)
		aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr))
		else $error("aw_valid dropped or aw_addr changed before aw_ready");

	w_hold: assert property (@(posedge clock) disable iff (reset)
		w_valid && !w_ready |=> w_valid && $stable(w_data) && $stable(w_strb))
		else $error("w_valid dropped or w_data or w_strb changed before w_ready");

	ar_hold: assert property (@(posedge clock) disable iff (reset)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
		else $error("ar_valid dropped or ar_addr changed before ar_ready");

	// one request at a time, so never a read and a write address together
	no_dual_addr: assert property (@(posedge clock) disable iff (reset)
		!(ar_valid && aw_valid))
		else $error("ar_valid and aw_valid high in the same cycle");

	done_pulse: assert property (@(posedge clock) disable iff (reset)
		done |=> !done)
		else $error("done high for more than one cycle");

endmodule

bind lsu_top lsu_checker #(
	.ADDR_WIDTH(ADDR_WIDTH)
) u_checker (
	.clock(clock),
	.reset(reset),
	.aw_valid(aw_valid),
	.aw_ready(aw_ready),
	.aw_addr(aw_addr),
	.w_valid(w_valid),
	.w_ready(w_ready),
	.w_data(w_data),
	.w_strb(w_strb),
	.ar_valid(ar_valid),
	.ar_ready(ar_ready),
	.ar_addr(ar_addr),
	.done(done)
);

// File: source/lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
	parameter int ADDR_WIDTH = 32
) (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      req_valid,
	input  logic                      req_is_store,
	input  lsu_pkg::mem_op_u          req_op,
	input  logic [ADDR_WIDTH-1:0]     req_addr,
	input  lsu_pkg::word_t            req_wdata,
	input  lsu_pkg::reg_addr_t        req_rd,
	output logic                      req_ready,
	output logic                      aw_valid,
	output logic [ADDR_WIDTH-1:0]     aw_addr,
	input  logic                      aw_ready,
	output logic                      w_valid,
	output lsu_pkg::bus_t             w_data,
	output lsu_pkg::strb_t            w_strb,
	input  logic                      w_ready,
	input  logic                      b_valid,
	output logic                      b_ready,
	output logic                      ar_valid,
	output logic [ADDR_WIDTH-1:0]     ar_addr,
	input  logic                      ar_ready,
	input  logic                      r_valid,
	input  lsu_pkg::bus_t             r_data,
	output logic                      r_ready,
	output logic                      rf_wen,
	output lsu_pkg::reg_addr_t        rf_waddr,
	output lsu_pkg::word_t            rf_wdata,
	output logic                      done
);
	logic                          busy_load;
	logic                          busy_store;
	logic                          read_finished;
	logic                          write_finished;
	lsu_pkg::mem_op_u              stage_op;
	logic [ADDR_WIDTH-1:0]         stage_addr;
	lsu_pkg::word_t                stage_wdata;
	lsu_pkg::reg_addr_t            stage_rd;
	logic [lsu_pkg::LANE_BITS-1:0] lane;
	logic                          need_second_rd;
	logic                          need_second_wr;
	logic                          second_rd;
	logic                          second_wr;
	lsu_pkg::word_t                load_data;

	assign lane = stage_addr[lsu_pkg::LANE_BITS-1:0];

	lsu_issue #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) u_issue (
		.clock(clock),
		.reset(reset),
		.req_valid(req_valid),
		.req_is_store(req_is_store),
		.req_op(req_op),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.req_rd(req_rd),
		.read_finished(read_finished),
		.write_finished(write_finished),
		.req_ready(req_ready),
		.busy_load(busy_load),
		.busy_store(busy_store),
		.done(done),
		.stage_op(stage_op),
		.stage_addr(stage_addr),
		.stage_wdata(stage_wdata),
		.stage_rd(stage_rd)
	);

	lsu_store_lanes u_store_lanes (
		.stage_op(stage_op),
		.lane(lane),
		.stage_wdata(stage_wdata),
		.second_wr(second_wr),
		.w_data(w_data),
		.w_strb(w_strb),
		.need_second_wr(need_second_wr)
	);

	lsu_write_fsm #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) u_write_fsm (
		.clock(clock),
		.reset(reset),
		.busy_store(busy_store),
		.need_second_wr(need_second_wr),
		.stage_addr(stage_addr),
		.aw_ready(aw_ready),
		.w_ready(w_ready),
		.b_valid(b_valid),
		.aw_valid(aw_valid),
		.aw_addr(aw_addr),
		.w_valid(w_valid),
		.b_ready(b_ready),
		.second_wr(second_wr),
		.write_finished(write_finished)
	);

	lsu_read_fsm #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) u_read_fsm (
		.clock(clock),
		.reset(reset),
		.busy_load(busy_load),
		.need_second_rd(need_second_rd),
		.stage_addr(stage_addr),
		.ar_ready(ar_ready),
		.r_valid(r_valid),
		.ar_valid(ar_valid),
		.ar_addr(ar_addr),
		.r_ready(r_ready),
		.second_rd(second_rd),
		.read_finished(read_finished)
	);

	lsu_load_align u_load_align (
		.clock(clock),
		.reset(reset),
		.stage_op(stage_op),
		.lane(lane),
		.second_rd(second_rd),
		.r_valid(r_valid),
		.r_ready(r_ready),
		.r_data(r_data),
		.need_second_rd(need_second_rd),
		.load_data(load_data)
	);

	// register file write only on the done cycle of a load
	assign rf_wen   = done && busy_load;
	assign rf_waddr = stage_rd;
	assign rf_wdata = load_data;

endmodule

// File: source/lsu_load_align.sv
`timescale 1ns/1ps

module lsu_load_align (
	input  logic                           clock,
	input  logic                           reset,
	input  lsu_pkg::mem_op_u               stage_op,
	input  logic [lsu_pkg::LANE_BITS-1:0]  lane,
	input  logic                           second_rd,
	input  logic                           r_valid,
	input  logic                           r_ready,
	input  lsu_pkg::bus_t                  r_data,
	output logic                           need_second_rd,
	output lsu_pkg::word_t                 load_data
);
	lsu_pkg::bus_t  held_beat;
	lsu_pkg::bus_t  low_beat;
	lsu_pkg::bus_t  high_beat;
	logic [127:0]   beat_pair;
	lsu_pkg::word_t picked;
	logic           signed_load;

	// halfword at lane 7 and word from lane 5 run into the next beat
	always_comb begin
		case (stage_op.load.size)
			lsu_pkg::SIZE_HALF: begin
				need_second_rd = (lane == 3'd7);
			end
			lsu_pkg::SIZE_WORD: begin
				need_second_rd = (lane > 3'd4);
			end
			default: begin
				need_second_rd = 1'b0;
			end
		endcase
	end

	// keep the first beat until the second one shows up
	always_ff @(posedge clock) begin
		if (reset) begin
			held_beat <= '0;
		end else if (r_valid && r_ready && need_second_rd && !second_rd) begin
			held_beat <= r_data;
		end
	end

	assign low_beat  = second_rd ? held_beat : r_data;
	assign high_beat = second_rd ? r_data : '0;
	assign beat_pair = {high_beat, low_beat};

	// little endian, so the lowest addressed byte ends up in bits 7:0
	assign picked = beat_pair[{lane, 3'b000} +: 32];

	assign signed_load = !stage_op.load.is_unsigned;

	always_comb begin
		case (stage_op.load.size)
			lsu_pkg::SIZE_BYTE: begin
				load_data = {{24{signed_load && picked[7]}}, picked[7:0]};
			end
			lsu_pkg::SIZE_HALF: begin
				load_data = {{16{signed_load && picked[15]}}, picked[15:0]};
			end
			default: begin
				load_data = picked;
			end
		endcase
	end

endmodule

// File: source/lsu_read_fsm.sv
`timescale 1ns/1ps

module lsu_read_fsm #(
	parameter int ADDR_WIDTH = 32
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  busy_load,
	input  logic                  need_second_rd,
	input  logic [ADDR_WIDTH-1:0] stage_addr,
	input  logic                  ar_ready,
	input  logic                  r_valid,
	output logic                  ar_valid,
	output logic [ADDR_WIDTH-1:0] ar_addr,
	output logic                  r_ready,
	output logic                  second_rd,
	output logic                  read_finished
);
	localparam logic [2:0] IDLE    = 3'd0;
	localparam logic [2:0] AR_WAIT = 3'd1;
	localparam logic [2:0] R_WAIT  = 3'd2;
	localparam logic [2:0] FINISH  = 3'd3;
	localparam logic [2:0] IDLE2   = 3'd4;

	logic [2:0]            state;
	logic [2:0]            next_state;
	logic                  last_beat;
	logic [ADDR_WIDTH-1:0] low_addr;

	assign last_beat = !need_second_rd || second_rd;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE, FINISH: begin
				next_state = busy_load ? AR_WAIT : IDLE;
			end
			AR_WAIT: begin
				if (ar_ready) begin
					next_state = R_WAIT;
				end
			end
			R_WAIT: begin
				if (r_valid) begin
					next_state = last_beat ? FINISH : IDLE2;
				end
			end
			IDLE2: begin
				next_state = AR_WAIT;
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ar_valid  <= 1'b0;
			r_ready   <= 1'b0;
			second_rd <= 1'b0;
		end else begin
			ar_valid <= (next_state == AR_WAIT);
			r_ready  <= (next_state == R_WAIT);
			if (next_state == IDLE2) begin
				second_rd <= 1'b1;
			end else if (next_state == FINISH) begin
				second_rd <= 1'b0;
			end
		end
	end

	// load data is taken from the live beat, so finish on its handshake
	assign read_finished = r_valid && r_ready && last_beat;

	assign low_addr = {stage_addr[ADDR_WIDTH-1:lsu_pkg::LANE_BITS], {lsu_pkg::LANE_BITS{1'b0}}};
	assign ar_addr  = second_rd ? low_addr + ADDR_WIDTH'(lsu_pkg::BEAT_BYTES) : low_addr;

endmodule

// File: source/lsu_write_fsm.sv
`timescale 1ns/1ps

module lsu_write_fsm #(
	parameter int ADDR_WIDTH = 32
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  busy_store,
	input  logic                  need_second_wr,
	input  logic [ADDR_WIDTH-1:0] stage_addr,
	input  logic                  aw_ready,
	input  logic                  w_ready,
	input  logic                  b_valid,
	output logic                  aw_valid,
	output logic [ADDR_WIDTH-1:0] aw_addr,
	output logic                  w_valid,
	output logic                  b_ready,
	output logic                  second_wr,
	output logic                  write_finished
);
	localparam logic [2:0] IDLE    = 3'd0;
	localparam logic [2:0] AW_WAIT = 3'd1;
	localparam logic [2:0] W_WAIT  = 3'd2;
	localparam logic [2:0] B_WAIT  = 3'd3;
	localparam logic [2:0] FINISH  = 3'd4;
	localparam logic [2:0] IDLE2   = 3'd5;

	logic [2:0]            state;
	logic [2:0]            next_state;
	logic                  last_beat;
	logic [ADDR_WIDTH-1:0] low_addr;

	assign last_beat = !need_second_wr || second_wr;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			// finish behaves like idle so a back-to-back store starts at once
			IDLE, FINISH: begin
				next_state = busy_store ? AW_WAIT : IDLE;
			end
			AW_WAIT: begin
				if (aw_ready) begin
					next_state = W_WAIT;
				end
			end
			W_WAIT: begin
				if (w_ready) begin
					next_state = B_WAIT;
				end
			end
			B_WAIT: begin
				if (b_valid) begin
					next_state = last_beat ? FINISH : IDLE2;
				end
			end
			IDLE2: begin
				next_state = AW_WAIT;
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

	// valids and ready follow the state being entered
	always_ff @(posedge clock) begin
		if (reset) begin
			aw_valid  <= 1'b0;
			w_valid   <= 1'b0;
			b_ready   <= 1'b0;
			second_wr <= 1'b0;
		end else begin
			aw_valid <= (next_state == AW_WAIT);
			w_valid  <= (next_state == W_WAIT);
			b_ready  <= (next_state == B_WAIT);
			if (next_state == IDLE2) begin
				second_wr <= 1'b1;
			end else if (next_state == FINISH) begin
				second_wr <= 1'b0;
			end
		end
	end

	// response of the last beat ends the store
	assign write_finished = b_valid && b_ready && last_beat;

	assign low_addr = {stage_addr[ADDR_WIDTH-1:lsu_pkg::LANE_BITS], {lsu_pkg::LANE_BITS{1'b0}}};
	assign aw_addr  = second_wr ? low_addr + ADDR_WIDTH'(lsu_pkg::BEAT_BYTES) : low_addr;

endmodule

// File: source/lsu_store_lanes.sv
`timescale 1ns/1ps

module lsu_store_lanes (
	input  lsu_pkg::mem_op_u               stage_op,
	input  logic [lsu_pkg::LANE_BITS-1:0]  lane,
	input  lsu_pkg::word_t                 stage_wdata,
	input  logic                           second_wr,
	output lsu_pkg::bus_t                  w_data,
	output lsu_pkg::strb_t                 w_strb,
	output logic                           need_second_wr
);
	// byte mask over two beats, before and after the lane shift
	logic [15:0]  size_mask;
	logic [15:0]  span;
	logic [127:0] shifted;

	always_comb begin
		case (stage_op.store.size)
			lsu_pkg::SIZE_BYTE: begin
				size_mask = 16'h0001;
			end
			lsu_pkg::SIZE_HALF: begin
				size_mask = 16'h0003;
			end
			lsu_pkg::SIZE_WORD: begin
				size_mask = 16'h000f;
			end
			default: begin
				size_mask = 16'h0000;
			end
		endcase
	end

	assign span = size_mask << lane;

	// bytes past lane 7 belong to the next aligned beat
	assign need_second_wr = |span[15:8];

	// shift the word up to its lane, then fold the upper beat back
	// onto the low lanes; that is a rotate over 64 bits, so the same
	// data word serves both beats and only the strobe changes
	assign shifted = {96'b0, stage_wdata} << {lane, 3'b000};
	assign w_data  = shifted[63:0] | shifted[127:64];

	assign w_strb = second_wr ? span[15:8] : span[7:0];

endmodule

// File: source/lsu_issue.sv
`timescale 1ns/1ps

module lsu_issue #(
	parameter int ADDR_WIDTH = 32
) (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      req_valid,
	input  logic                      req_is_store,
	input  lsu_pkg::mem_op_u          req_op,
	input  logic [ADDR_WIDTH-1:0]     req_addr,
	input  lsu_pkg::word_t            req_wdata,
	input  lsu_pkg::reg_addr_t        req_rd,
	input  logic                      read_finished,
	input  logic                      write_finished,
	output logic                      req_ready,
	output logic                      busy_load,
	output logic                      busy_store,
	output logic                      done,
	output lsu_pkg::mem_op_u          stage_op,
	output logic [ADDR_WIDTH-1:0]     stage_addr,
	output lsu_pkg::word_t            stage_wdata,
	output lsu_pkg::reg_addr_t        stage_rd
);
	logic stage_valid;
	logic stage_is_store;
	logic ready_go;

	// valid bit and request kind
	always_ff @(posedge clock) begin
		if (reset) begin
			stage_valid    <= 1'b0;
			stage_is_store <= 1'b0;
		end else if (req_ready) begin
			stage_valid    <= req_valid;
			stage_is_store <= req_is_store;
		end
	end

	// request payload
	always_ff @(posedge clock) begin
		if (req_ready && req_valid) begin
			stage_op    <= req_op;
			stage_addr  <= req_addr;
			stage_wdata <= req_wdata;
			stage_rd    <= req_rd;
		end
	end

	assign busy_load  = stage_valid && !stage_is_store;
	assign busy_store = stage_valid && stage_is_store;

	// only the machine matching the request kind can finish it
	assign ready_go  = stage_is_store ? write_finished : read_finished;
	assign req_ready = !stage_valid || ready_go;
	assign done      = stage_valid && ready_go;

endmodule

// File: source/lsu_pkg.sv
package lsu_pkg;

	// the lane logic assumes a 32-bit word on a 64-bit beat
	typedef logic [31:0] word_t;
	typedef logic [63:0] bus_t;
	typedef logic [7:0] strb_t;
	typedef logic [4:0] reg_addr_t;

	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} mem_size_e;

	// operation field, read through the load or the store view
	// depending on the is_store bit that travels with it
	typedef union packed {
		struct packed {
			mem_size_e size;
			logic      is_unsigned;
		} load;
		struct packed {
			mem_size_e size;
			logic      spare;
		} store;
	} mem_op_u;

	// low address bits that pick a byte lane in one beat
	localparam int LANE_BITS = 3;

	// address step from the first beat to the second
	localparam int BEAT_BYTES = 8;

endpackage
